//--- alu_core.f
design/alu_ops_pkg.sv
design/ccr_pkg.sv
design/alu_sequencer.sv
design/integer_unit.sv
design/bcd_unit.sv
design/ccr_unit.sv
design/alu_core.sv
testbench/alu_core_tb.sv

//--- design/alu_core.sv
// ==========================================================
// Integer ALU top level with init/req/ack handshake.
// Result is valid one cycle after req rises; init must not
// be pulsed while busy is high.
// ==========================================================
`timescale 1ns/1ps

module alu_core (
    input  logic                   CLK,
    input  logic                   reset,
    input  logic                   init,
    input  logic                   load_op1,
    input  logic                   load_op2,
    input  logic [31:0]            op1_in,
    input  logic [31:0]            op2_in,
    input  alu_ops_pkg::alu_cmd_t  cmd_in,
    input  logic                   ack,
    input  logic                   cc_update,
    output logic                   busy,
    output logic                   req,
    output logic [31:0]            result,
    output ccr_pkg::flags_t        ccr,
    output logic                   cond
);

    alu_ops_pkg::alu_cmd_t  cmd;
    alu_ops_pkg::operands_t operands;
    ccr_pkg::unit_out_t     int_out;
    ccr_pkg::unit_out_t     bcd_out;
    ccr_pkg::flags_t        flags;

    alu_sequencer alu_sequencer_i (
        .CLK      (CLK),
        .reset    (reset),
        .init     (init),
        .load_op1 (load_op1),
        .load_op2 (load_op2),
        .op1_in   (op1_in),
        .op2_in   (op2_in),
        .cmd_in   (cmd_in),
        .ack      (ack),
        .int_out  (int_out),
        .bcd_out  (bcd_out),
        .cmd      (cmd),
        .operands (operands),
        .busy     (busy),
        .req      (req),
        .result   (result),
        .flags    (flags)
    );

    integer_unit integer_unit_i (
        .cmd      (cmd),
        .operands (operands),
        .ccr      (ccr),
        .out      (int_out)
    );

    bcd_unit bcd_unit_i (
        .cmd      (cmd),
        .operands (operands),
        .ccr      (ccr),
        .out      (bcd_out)
    );

    ccr_unit ccr_unit_i (
        .CLK       (CLK),
        .reset     (reset),
        .ack       (ack),
        .cc_update (cc_update),
        .flags     (flags),
        .cond_code (cmd.cond),
        .ccr       (ccr),
        .cond      (cond)
    );

endmodule

//--- design/alu_ops_pkg.sv
// ==========================================================
// Operation, size and command types of the integer ALU.
// Codes 5'h15 and up are unused and give don't-care results.
// ==========================================================

package alu_ops_pkg;

    typedef enum logic [4:0] {
        ADD   = 5'h00, ADDX  = 5'h01, SUB   = 5'h02, SUBX  = 5'h03,
        CMP   = 5'h04, NEG   = 5'h05, NEGX  = 5'h06,                 // Arithmetic
        CLR   = 5'h07, MOVE  = 5'h08, TST   = 5'h09,                 // Moves
        AND_B = 5'h0A, OR_B  = 5'h0B, EOR   = 5'h0C, NOT_B = 5'h0D,  // Logic
        BTST  = 5'h0E, BCHG  = 5'h0F, BCLR  = 5'h10, BSET  = 5'h11,  // Single bit
        ABCD  = 5'h12, SBCD  = 5'h13, NBCD  = 5'h14                  // Packed BCD
    } alu_op_t;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        WORD = 2'b01,
        LONG = 2'b10
    } op_size_t;

    // Command word, 16 bits
    typedef struct packed {
        alu_op_t    op;
        op_size_t   size;
        logic [3:0] cond;     // Condition field of the instruction word
        logic [4:0] bit_pos;  // Bit number for BTST/BCHG/BCLR/BSET
    } alu_cmd_t;

    typedef struct packed {
        logic [31:0] op1;  // Source
        logic [31:0] op2;  // Destination
    } operands_t;

endpackage

//--- design/alu_sequencer.sv
// ==========================================================
// Operand/command latches, busy/req handshake and the result
// register. Operands may be loaded before or with init.
// ==========================================================
`timescale 1ns/1ps

module alu_sequencer (
    input  logic                    CLK,
    input  logic                    reset,
    input  logic                    init,
    input  logic                    load_op1,
    input  logic                    load_op2,
    input  logic [31:0]             op1_in,
    input  logic [31:0]             op2_in,
    input  alu_ops_pkg::alu_cmd_t   cmd_in,
    input  logic                    ack,
    input  ccr_pkg::unit_out_t      int_out,
    input  ccr_pkg::unit_out_t      bcd_out,
    output alu_ops_pkg::alu_cmd_t   cmd,
    output alu_ops_pkg::operands_t  operands,
    output logic                    busy,
    output logic                    req,
    output logic [31:0]             result,
    output ccr_pkg::flags_t         flags
);

    logic [31:0]        op1_buf;
    logic [31:0]        op2_buf;
    logic               is_bcd;
    ccr_pkg::unit_out_t sel_out;
    ccr_pkg::unit_out_t out_q;

    // ==========================================================
    // Operand buffers and command latch
    // ==========================================================
    always_ff @(posedge CLK) begin
        if (load_op1)
            op1_buf <= op1_in;
        if (load_op2)
            op2_buf <= op2_in;
        if (init) begin
            cmd          <= cmd_in;
            operands.op1 <= load_op1 ? op1_in : op1_buf;  // Same-cycle load bypass
            operands.op2 <= load_op2 ? op2_in : op2_buf;
        end
    end

    // Handshake
    always_ff @(posedge CLK) begin
        if (reset) begin
            busy <= 1'b0;
            req  <= 1'b0;
        end else if (init) begin
            busy <= 1'b1;
            req  <= 1'b1;
        end else if (ack) begin
            busy <= 1'b0;
            req  <= 1'b0;
        end
    end

    // ==========================================================
    // Unit select and result register
    // ==========================================================
    assign is_bcd = (cmd.op == alu_ops_pkg::ABCD) || (cmd.op == alu_ops_pkg::SBCD) ||
                    (cmd.op == alu_ops_pkg::NBCD);
    assign sel_out = is_bcd ? bcd_out : int_out;

    always_ff @(posedge CLK) begin
        if (req)
            out_q <= sel_out;  // Operands are frozen, so value holds under back-pressure
    end

    assign result = out_q.result;
    assign flags  = out_q.flags;

endmodule

//--- design/bcd_unit.sv
// ==========================================================
// Two-digit packed BCD add, subtract and negate.
// Byte only; digits above 9 on input give undefined results.
// ==========================================================
`timescale 1ns/1ps

module bcd_unit (
    input  alu_ops_pkg::alu_cmd_t  cmd,
    input  alu_ops_pkg::operands_t operands,
    input  ccr_pkg::flags_t        ccr,
    output ccr_pkg::unit_out_t     out
);

    always_comb begin
        logic [4:0] lo;
        logic [4:0] hi;
        logic       c_lo;
        logic       c_hi;
        logic [3:0] d_lo;
        logic [3:0] d_hi;
        logic [7:0] bcd;

        // Low digit, borrow shows up as a wrap above 9
        case (cmd.op)
            alu_ops_pkg::ABCD: lo = {1'b0, operands.op2[3:0]} + {1'b0, operands.op1[3:0]} +
                                    {4'd0, ccr.x};
            alu_ops_pkg::NBCD: lo = 5'd0 - {1'b0, operands.op2[3:0]} - {4'd0, ccr.x};
            default:           lo = {1'b0, operands.op2[3:0]} - {1'b0, operands.op1[3:0]} -
                                    {4'd0, ccr.x};
        endcase
        c_lo = (lo > {1'b0, ccr_pkg::BCD_DIGIT_MAX});

        // High digit takes the decimal carry of the low one
        case (cmd.op)
            alu_ops_pkg::ABCD: hi = {1'b0, operands.op2[7:4]} + {1'b0, operands.op1[7:4]} +
                                    {4'd0, c_lo};
            alu_ops_pkg::NBCD: hi = 5'd0 - {1'b0, operands.op2[7:4]} - {4'd0, c_lo};
            default:           hi = {1'b0, operands.op2[7:4]} - {1'b0, operands.op1[7:4]} -
                                    {4'd0, c_lo};
        endcase
        c_hi = (hi > {1'b0, ccr_pkg::BCD_DIGIT_MAX});

        if (cmd.op == alu_ops_pkg::ABCD) begin
            d_lo = lo[3:0] + (c_lo ? ccr_pkg::BCD_CORRECTION : 4'd0);
            d_hi = hi[3:0] + (c_hi ? ccr_pkg::BCD_CORRECTION : 4'd0);
        end else begin
            d_lo = lo[3:0] - (c_lo ? ccr_pkg::BCD_CORRECTION : 4'd0);
            d_hi = hi[3:0] - (c_hi ? ccr_pkg::BCD_CORRECTION : 4'd0);
        end
        bcd = {d_hi, d_lo};

        out.result = {24'h0, bcd};
        out.flags  = {c_hi, 1'b0, (bcd == 8'h00) & ccr.z, 1'b0, c_hi};  // N, V defined 0
    end

endmodule

//--- design/ccr_pkg.sv
// ==========================================================
// Condition code definitions shared by the execution units.
// Flag order matches the low five bits of the 68k status reg.
// ==========================================================

package ccr_pkg;

    typedef struct packed {
        logic x;
        logic n;
        logic z;
        logic v;
        logic c;
    } flags_t;

    // Bit positions inside flags_t
    localparam int FLAG_X = 4;
    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_V = 1;
    localparam int FLAG_C = 0;

    // Decimal adjust
    localparam logic [3:0] BCD_DIGIT_MAX  = 4'd9;
    localparam logic [3:0] BCD_CORRECTION = 4'd6;

    // What each execution unit hands back
    typedef struct packed {
        logic [31:0] result;
        flags_t      flags;
    } unit_out_t;

endpackage

//--- design/ccr_unit.sv
// ==========================================================
// Condition code register (XNZVC) and the 68k condition test.
// Flags load only on ack with cc_update; cond is combinational.
// ==========================================================
`timescale 1ns/1ps

module ccr_unit (
    input  logic            CLK,
    input  logic            reset,
    input  logic            ack,
    input  logic            cc_update,
    input  ccr_pkg::flags_t flags,
    input  logic [3:0]      cond_code,
    output ccr_pkg::flags_t ccr,
    output logic            cond
);

    logic n_xor_v;

    always_ff @(posedge CLK) begin
        if (reset)
            ccr <= '0;
        else if (ack && cc_update)
            ccr <= flags;
    end

    // ==========================================================
    // Condition test
    // ==========================================================
    assign n_xor_v = ccr.n ^ ccr.v;

    always_comb begin
        case (cond_code)
            4'h0: cond = 1'b1;                  // T
            4'h1: cond = 1'b0;                  // F
            4'h2: cond = ~(ccr.z | ccr.c);      // HI
            4'h3: cond = ccr.z | ccr.c;         // LS
            4'h4: cond = ~ccr.c;                // CC
            4'h5: cond = ccr.c;                 // CS
            4'h6: cond = ~ccr.z;                // NE
            4'h7: cond = ccr.z;                 // EQ
            4'h8: cond = ~ccr.v;                // VC
            4'h9: cond = ccr.v;                 // VS
            4'hA: cond = ~ccr.n;                // PL
            4'hB: cond = ccr.n;                 // MI
            4'hC: cond = ~n_xor_v;              // GE
            4'hD: cond = n_xor_v;               // LT
            4'hE: cond = ~ccr.z & ~n_xor_v;     // GT
            default: cond = ccr.z | n_xor_v;    // LE
        endcase
    end

endmodule

//--- design/integer_unit.sv
// ==========================================================
// Sized add/sub/compare/negate, logic, move and single-bit
// operations with 68k flag rules. Purely combinational.
// Bit number is used modulo 32 for every size.
// ==========================================================
`timescale 1ns/1ps

module integer_unit (
    input  alu_ops_pkg::alu_cmd_t  cmd,
    input  alu_ops_pkg::operands_t operands,
    input  ccr_pkg::flags_t        ccr,
    output ccr_pkg::unit_out_t     out
);

    function automatic logic [31:0] sign_ext(input logic [31:0] val,
                                             input alu_ops_pkg::op_size_t size);
        case (size)
            alu_ops_pkg::BYTE: sign_ext = {{24{val[7]}}, val[7:0]};
            alu_ops_pkg::WORD: sign_ext = {{16{val[15]}}, val[15:0]};
            default:           sign_ext = val;
        endcase
    endfunction

    always_comb begin
        logic [31:0] src;
        logic [31:0] dst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] arith;
        logic [31:0] raw;
        logic [31:0] res_se;
        logic        cin;
        logic        is_sub;
        logic        am;
        logic        bm;
        logic        rm;
        logic        zr;
        logic        c;
        logic        v;
        logic        bit_old;

        src = sign_ext(operands.op1, cmd.size);
        dst = sign_ext(operands.op2, cmd.size);

        // Arithmetic forms a +/- b +/- carry
        a      = dst;
        b      = src;
        cin    = 1'b0;
        is_sub = 1'b1;
        case (cmd.op)
            alu_ops_pkg::ADD:  is_sub = 1'b0;
            alu_ops_pkg::ADDX: begin
                is_sub = 1'b0;
                cin    = ccr.x;
            end
            alu_ops_pkg::SUBX: cin = ccr.x;
            alu_ops_pkg::NEG: begin
                a = 32'h0;
                b = dst;
            end
            alu_ops_pkg::NEGX: begin
                a   = 32'h0;
                b   = dst;
                cin = ccr.x;
            end
            default: ;
        endcase
        arith = is_sub ? (a - b - {31'd0, cin}) : (a + b + {31'd0, cin});

        bit_old = operands.op2[cmd.bit_pos];
        raw     = operands.op2;  // BTST and unused codes
        case (cmd.op)
            alu_ops_pkg::ADD, alu_ops_pkg::ADDX, alu_ops_pkg::SUB, alu_ops_pkg::SUBX,
            alu_ops_pkg::CMP, alu_ops_pkg::NEG, alu_ops_pkg::NEGX:
                raw = sign_ext(arith, cmd.size);
            alu_ops_pkg::CLR:   raw = 32'h0;
            alu_ops_pkg::MOVE:  raw = operands.op1;
            alu_ops_pkg::AND_B: raw = operands.op1 & operands.op2;
            alu_ops_pkg::OR_B:  raw = operands.op1 | operands.op2;
            alu_ops_pkg::EOR:   raw = operands.op1 ^ operands.op2;
            alu_ops_pkg::NOT_B: raw = ~operands.op2;
            alu_ops_pkg::BCHG:  raw[cmd.bit_pos] = ~bit_old;
            alu_ops_pkg::BCLR:  raw[cmd.bit_pos] = 1'b0;
            alu_ops_pkg::BSET:  raw[cmd.bit_pos] = 1'b1;
            default: ;
        endcase

        // Flags from the sized sign bits
        res_se = sign_ext(raw, cmd.size);
        rm = res_se[31];
        zr = (res_se == 32'h0);
        am = a[31];
        bm = b[31];
        if (is_sub) begin
            c = (bm & ~am) | (rm & bm) | (rm & ~am);  // Borrow
            v = (~am & bm & rm) | (am & ~bm & ~rm);
        end else begin
            c = (am & bm) | (~rm & am) | (~rm & bm);
            v = (am & bm & ~rm) | (~am & ~bm & rm);
        end

        out.result = raw;
        out.flags  = ccr;
        case (cmd.op)
            alu_ops_pkg::ADD, alu_ops_pkg::SUB, alu_ops_pkg::NEG:
                out.flags = {c, rm, zr, v, c};
            alu_ops_pkg::ADDX, alu_ops_pkg::SUBX, alu_ops_pkg::NEGX:
                out.flags = {c, rm, zr & ccr.z, v, c};  // Sticky Z across a chain
            alu_ops_pkg::CMP:
                out.flags = {ccr.x, rm, zr, v, c};
            alu_ops_pkg::CLR:
                out.flags = {ccr.x, 4'b0100};
            alu_ops_pkg::MOVE, alu_ops_pkg::TST, alu_ops_pkg::AND_B, alu_ops_pkg::OR_B,
            alu_ops_pkg::EOR, alu_ops_pkg::NOT_B:
                out.flags = {ccr.x, rm, zr, 2'b00};
            alu_ops_pkg::BTST, alu_ops_pkg::BCHG, alu_ops_pkg::BCLR, alu_ops_pkg::BSET:
                out.flags.z = ~bit_old;
            default: ;
        endcase
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds and runs the ALU testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module alu_core_tb \
    -f alu_core.f -Mdir obj_dir -o alu_core_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Build failed with status $status, see build.log"
    exit 1
fi

./obj_dir/alu_core_sim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status, see sim.log"
    exit 1
fi

if grep -qx "Done: no errors" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi

//--- testbench/alu_core_stim.txt
// cmd(op,size,cond,bit_pos) op1 op2 cc_update result flags(XNZVC) cond
// Row with cmd FFFFFFFF ends the list
0120 0000007F 00000001 1 FFFFFF80 0A 1  // ADD.b overflow, VS
00A0 000000FF 00000001 1 00000000 15 1  // ADD.b carry, CS
0240 00001234 00000001 1 00001235 00 1  // ADD.w, HI
15A0 00000001 00000000 1 FFFFFFFF 19 1  // SUB.l borrow, LT
20E0 00000003 00000003 1 00000000 14 1  // CMP.b equal, X kept, EQ
1380 00000001 00008000 1 00007FFF 02 0  // SUB.w overflow, GE
2960 00000000 00000001 1 FFFFFFFF 19 1  // NEG.b, MI
2900 00000000 00000080 1 FFFFFF80 1B 0  // NEG.b overflow, VC
0400 FFFFFFFF 00000001 1 00000000 15 1  // ADD.l to zero, T
0CE0 FFFFFFFF 00000000 1 00000000 15 1  // ADDX.l zero keeps Z, EQ
0CC0 00000000 00000000 1 00000001 00 1  // ADDX.l nonzero clears Z, NE
1880 00000001 00000000 1 FFFFFFFF 19 0  // SUBX.b borrow, CC
3140 00000000 00000000 1 FFFFFFFF 19 0  // NEGX.b with X, PL
55E0 F0F0F0F0 FF00FF00 1 F000F000 18 1  // AND.l, LE
5BC0 00000F00 000000F0 1 00000FF0 10 1  // OR.w, GT
60E0 000000AA 000000AA 1 00000000 14 1  // EOR.b, EQ
6820 00000000 12345678 1 EDCBA987 18 0  // NOT.b, F
3A60 00000000 12345678 1 00000000 14 1  // CLR.w, LS
4560 80000000 00000000 1 80000000 18 1  // MOVE.l, MI
4AE0 00000000 00000000 0 00000000 18 0  // TST.w without update, EQ
74C4 00000000 00000010 1 00000010 18 1  // BTST bit 4, NE
7CE0 00000000 00000010 1 00000011 1C 1  // BCHG bit 0, EQ
84DF 00000000 80000001 1 00000001 18 1  // BCLR bit 31, NE
884C 00000000 00000000 1 00001000 1C 0  // BSET bit 12, HI
9080 00000019 00000028 1 00000048 00 1  // ABCD with X, CC
90A0 00000055 00000045 1 00000000 11 1  // ABCD decimal carry, CS
9900 00000009 00000010 1 00000000 00 1  // SBCD with X, VC
A180 00000000 00000001 1 00000099 11 1  // NBCD borrow, GE
FFFFFFFF

//--- testbench/alu_core_tb.sv
// ==========================================================
// Replays vectors from testbench/alu_core_stim.txt, 7 words per
// vector, ended by a row with command FFFFFFFF. Needs a run
// from the project root with assertions enabled.
// ==========================================================
`timescale 1ns/1ps

module alu_core_tb;

    localparam int MAX_VEC     = 64;
    localparam int COLS        = 7;   // cmd op1 op2 cc_update result flags cond
    localparam int CLK_HALF    = 50;
    localparam int DRIVE_DELAY = 10;

    logic                  CLK;
    logic                  reset;
    logic                  init;
    logic                  load_op1;
    logic                  load_op2;
    logic [31:0]           op1_in;
    logic [31:0]           op2_in;
    alu_ops_pkg::alu_cmd_t cmd_in;
    logic                  ack;
    logic                  cc_update;
    logic                  busy;
    logic                  req;
    logic [31:0]           result;
    ccr_pkg::flags_t       ccr;
    logic                  cond;

    logic [31:0] stim_mem [0:MAX_VEC*COLS-1];
    logic [31:0] rng_state;
    int          num_vec;
    int          cur_vec;
    int          errors;
    int          checks;
    int          cycles;
    int          cycle_limit;

    alu_core alu_core_i (
        .CLK       (CLK),
        .reset     (reset),
        .init      (init),
        .load_op1  (load_op1),
        .load_op2  (load_op2),
        .op1_in    (op1_in),
        .op2_in    (op2_in),
        .cmd_in    (cmd_in),
        .ack       (ack),
        .cc_update (cc_update),
        .busy      (busy),
        .req       (req),
        .result    (result),
        .ccr       (ccr),
        .cond      (cond)
    );

    initial begin
        CLK = 1'b0;
        forever #CLK_HALF CLK = ~CLK;
    end

    // Watchdog
    always @(posedge CLK) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles in vector %0d", cycles, cur_vec);
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] next_lcg(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic next_cycle();
        @(posedge CLK);
        #DRIVE_DELAY;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s (vector %0d): got %h expected %h", name, cur_vec, got, exp);
        end
    endtask

    task automatic check_flags(input logic [4:0] exp);
        check_value("ccr.x", 32'(ccr[ccr_pkg::FLAG_X]), 32'(exp[ccr_pkg::FLAG_X]));
        check_value("ccr.n", 32'(ccr[ccr_pkg::FLAG_N]), 32'(exp[ccr_pkg::FLAG_N]));
        check_value("ccr.z", 32'(ccr[ccr_pkg::FLAG_Z]), 32'(exp[ccr_pkg::FLAG_Z]));
        check_value("ccr.v", 32'(ccr[ccr_pkg::FLAG_V]), 32'(exp[ccr_pkg::FLAG_V]));
        check_value("ccr.c", 32'(ccr[ccr_pkg::FLAG_C]), 32'(exp[ccr_pkg::FLAG_C]));
    endtask

    task automatic run_vector(input int idx);
        int          base;
        int          hold_off;

        base      = idx * COLS;
        cur_vec   = idx;
        op1_in    = stim_mem[base+1];
        op2_in    = stim_mem[base+2];
        cc_update = stim_mem[base+3][0];
        load_op1  = 1'b1;
        load_op2  = 1'b1;
        if (idx % 2 == 1) begin  // Odd vectors load a cycle ahead of init
            next_cycle();
            load_op1 = 1'b0;
            load_op2 = 1'b0;
            op1_in   = ~stim_mem[base+1];
            op2_in   = ~stim_mem[base+2];
        end
        cmd_in = alu_ops_pkg::alu_cmd_t'(stim_mem[base][15:0]);
        init   = 1'b1;
        next_cycle();
        init     = 1'b0;
        load_op1 = 1'b0;
        load_op2 = 1'b0;
        while (req !== 1'b1)
            next_cycle();
        check_value("busy", 32'(busy), 32'd1);
        next_cycle();  // Result register loaded on this edge
        check_value("result", result, stim_mem[base+4]);

        // Back-pressure
        rng_state = next_lcg(rng_state);
        hold_off  = int'(rng_state[17:16]);
        repeat (hold_off) begin
            next_cycle();
            check_value("req", 32'(req), 32'd1);
            check_value("result", result, stim_mem[base+4]);
        end

        ack = 1'b1;
        next_cycle();
        ack = 1'b0;
        check_value("req", 32'(req), 32'd0);
        check_value("busy", 32'(busy), 32'd0);
        check_flags(stim_mem[base+5][4:0]);
        check_value("cond", 32'(cond), stim_mem[base+6]);
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin
        reset     = 1'b1;
        init      = 1'b0;
        load_op1  = 1'b0;
        load_op2  = 1'b0;
        op1_in    = 32'h0;
        op2_in    = 32'h0;
        cmd_in    = '0;
        ack       = 1'b0;
        cc_update = 1'b0;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        cur_vec   = -1;
        rng_state = 32'd5031;

        $readmemh("testbench/alu_core_stim.txt", stim_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC && stim_mem[num_vec*COLS] !== 32'hFFFF_FFFF)
            num_vec++;
        cycle_limit = 20 * num_vec + 50;

        repeat (2) @(posedge CLK);
        #DRIVE_DELAY reset = 1'b0;

        checks++;
        assert (num_vec > 0 && num_vec < MAX_VEC) else begin
            errors++;
            $display("Stimulus file is missing, empty or lacks its end marker");
        end
        if (errors == 0) begin
            check_value("busy", 32'(busy), 32'd0);
            check_value("req", 32'(req), 32'd0);
            check_value("ccr", 32'(ccr), 32'd0);
            for (int i = 0; i < num_vec; i++)
                run_vector(i);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule
